/* tagmem_pkg.sv */
/*
 * shared widths and encodings for the tagged memory subsystem
 * the address width is a module parameter and does not live here
 * service registers sit at fixed offsets below the all-ones word address
 */
package tagmem_pkg;

    localparam int DATA_W   = 64;           // memory word
    localparam int TAG_W    = 8;            // tag per word
    localparam int LEN_W    = 8;            // word count of one transaction
    localparam int LOCK_BIT = 55;           // semaphore bit set by atomic write

    // one memory word, read either as plain data or as a semaphore
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [DATA_W-LOCK_BIT-2:0] hi; // high byte
            logic                       lock;
            logic [LOCK_BIT-1:0]        lo; // low 55 bits
        } sem;
    } mem_word_t;

    // offsets below the top address
    localparam int SVC_SYNDROME = 0;        // hamming syndrome, reads zero
    localparam int SVC_LASTADDR = 1;        // start address of previous transaction
    localparam int SVC_ECCMODE  = 2;        // correction mode, reads zero

endpackage

/* tagmem_ram.sv */
/*
 * word-addressed RAM, 64-bit data plus 8-bit tag per word
 * astb latches the address, rd/wr then step through consecutive words
 * atomic rd/wr do not advance; atomic wr forces the lock bit to one
 * service registers at the top three addresses are read-only
 * read data appears one cycle after the rd strobe
 */
`timescale 1ns/10ps

module tagmem_ram
    import tagmem_pkg::*;
#(
    parameter int ADDR_W = 20
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic [DATA_W-1:0] i_ad,     // address or write data
    input  logic [TAG_W-1:0]  i_tag,    // write tag
    input  logic              i_astb,   // address strobe
    input  logic              i_atomic, // read-modify-write access
    input  logic              i_rd,     // read strobe
    input  logic              i_wr,     // write strobe
    output logic [DATA_W-1:0] o_data,   // read data, one cycle after rd
    output logic [TAG_W-1:0]  o_tag     // read tag
);

    localparam int DEPTH = 2 ** ADDR_W;
    localparam logic [ADDR_W-1:0] ADDR_TOP  = '1;
    localparam logic [ADDR_W-1:0] ADDR_SYN  = ADDR_TOP - ADDR_W'(SVC_SYNDROME);
    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_TOP - ADDR_W'(SVC_LASTADDR);
    localparam logic [ADDR_W-1:0] ADDR_MODE = ADDR_TOP - ADDR_W'(SVC_ECCMODE);

    logic [DATA_W-1:0] mem  [DEPTH];    // data words
    logic [TAG_W-1:0]  tags [DEPTH];    // tag per word
    logic [ADDR_W-1:0] waddr;           // current word address, steps in batch mode
    logic [ADDR_W-1:0] saddr;           // address as latched by the last astb
    logic [ADDR_W-1:0] laddr;           // start address of the transaction before
    mem_word_t         wr_word;         // word as it goes into the array
    logic              is_svc;          // current address hits a service register

    assign is_svc = (waddr == ADDR_SYN) || (waddr == ADDR_LAST) || (waddr == ADDR_MODE);

    // atomic write marks the semaphore as taken
    always_comb begin
        wr_word.raw = i_ad;
        if (i_atomic)
            wr_word.sem.lock = 1'b1;
    end

    // address latch and batch increment
    always_ff @(posedge clk) begin
        if (i_reset) begin
            waddr <= '0;
            saddr <= '0;
            laddr <= '0;
        end else if (i_astb) begin
            laddr <= saddr;             // previous transaction's start
            saddr <= i_ad[ADDR_W-1:0];
            waddr <= i_ad[ADDR_W-1:0];
        end else if (!i_atomic && (i_wr || (i_rd && !is_svc))) begin
            waddr <= waddr + 1'b1;      // service reads hold the address
        end
    end

    // array store, service addresses are not writable
    always_ff @(posedge clk) begin
        if (i_wr && !i_astb && !is_svc) begin
            mem[waddr]  <= wr_word.raw;
            tags[waddr] <= i_tag;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (i_rd && !i_astb) begin
            if (waddr == ADDR_LAST) begin
                o_data <= DATA_W'(laddr);
                o_tag  <= '0;
            end else if (is_svc) begin
                o_data <= '0;           // syndrome and mode, no coding here
                o_tag  <= '0;
            end else begin
                o_data <= mem[waddr];
                o_tag  <= tags[waddr];
            end
        end
    end

endmodule

/* bus_arbiter.sv */
/*
 * two-peer round-robin arbiter for the shared memory bus
 * grant is held for a whole transaction, until the owner drops its request
 * a new grant rises one cycle after the bus is seen free
 * strobes of the peer without grant are forced to zero
 */
`timescale 1ns/10ps

module bus_arbiter
    import tagmem_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_req0,
    output logic              o_gnt0,
    input  logic              i_astb0,
    input  logic              i_rd0,
    input  logic              i_wr0,
    input  logic              i_atomic0,
    input  logic [DATA_W-1:0] i_ad0,
    input  logic [TAG_W-1:0]  i_tag0,
    input  logic              i_req1,
    output logic              o_gnt1,
    input  logic              i_astb1,
    input  logic              i_rd1,
    input  logic              i_wr1,
    input  logic              i_atomic1,
    input  logic [DATA_W-1:0] i_ad1,
    input  logic [TAG_W-1:0]  i_tag1,
    output logic              o_astb,   // to the RAM
    output logic              o_rd,
    output logic              o_wr,
    output logic              o_atomic,
    output logic [DATA_W-1:0] o_ad,
    output logic [TAG_W-1:0]  o_tag
);

    logic [1:0] gnt;                    // owner, one-hot, zero when bus free
    logic       last;                   // last winner
    logic       pick;                   // next winner when bus is free
    logic       owner_req;              // owner still holds its request

    assign pick      = (i_req0 && i_req1) ? ~last : i_req1; // alternate on a tie
    assign owner_req = (gnt[0] && i_req0) || (gnt[1] && i_req1);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            gnt  <= 2'b00;
            last <= 1'b1;               // port 0 wins the first tie
        end else if (|gnt) begin
            if (!owner_req)
                gnt <= 2'b00;           // transaction over, release
        end else if (i_req0 || i_req1) begin
            gnt  <= pick ? 2'b10 : 2'b01;
            last <= pick;
        end
    end

    assign o_gnt0 = gnt[0];
    assign o_gnt1 = gnt[1];

    // AND-OR mux, only the owner gets through
    assign o_astb   = (gnt[0] && i_astb0) || (gnt[1] && i_astb1);
    assign o_rd     = (gnt[0] && i_rd0) || (gnt[1] && i_rd1);
    assign o_wr     = (gnt[0] && i_wr0) || (gnt[1] && i_wr1);
    assign o_atomic = (gnt[0] && i_atomic0) || (gnt[1] && i_atomic1);
    assign o_ad     = ({DATA_W{gnt[0]}} & i_ad0) | ({DATA_W{gnt[1]}} & i_ad1);
    assign o_tag    = ({TAG_W{gnt[0]}} & i_tag0) | ({TAG_W{gnt[1]}} & i_tag1);

endmodule

/* mem_port.sv */
/*
 * requester peer: turns one command into astb/rd/wr strobes on the shared bus
 * a length of zero moves 256 words; atomic commands ignore the length
 * read words come with a one-cycle o_rvalid and cannot be held off
 * a write with no word offered stalls the bus while keeping the grant
 */
`timescale 1ns/10ps

module mem_port
    import tagmem_pkg::*;
#(
    parameter int ADDR_W = 20
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    input  logic [ADDR_W-1:0] i_cmd_addr,
    input  logic [LEN_W-1:0]  i_cmd_len,
    input  logic              i_cmd_wr,
    input  logic              i_cmd_atomic,
    input  logic [DATA_W-1:0] i_wdata,
    input  logic [TAG_W-1:0]  i_wtag,
    input  logic              i_wvalid,
    output logic              o_wready,
    output logic [DATA_W-1:0] o_rdata,
    output logic [TAG_W-1:0]  o_rtag,
    output logic              o_rvalid,
    output logic              o_done,     // end of transaction
    input  logic              i_gnt,
    output logic              o_req,
    output logic              o_astb,
    output logic              o_rd,
    output logic              o_wr,
    output logic              o_atomic,
    output logic [DATA_W-1:0] o_ad,
    output logic [TAG_W-1:0]  o_tag,
    input  logic [DATA_W-1:0] i_bus_data, // RAM read data
    input  logic [TAG_W-1:0]  i_bus_tag
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_WAIT   = 3'd1; // request up, no grant yet
    localparam logic [2:0] S_ADDR   = 3'd2;
    localparam logic [2:0] S_XFER   = 3'd3;
    localparam logic [2:0] S_AT_RD  = 3'd4;
    localparam logic [2:0] S_AT_CAP = 3'd5;
    localparam logic [2:0] S_AT_WR  = 3'd6;
    localparam logic [2:0] S_FINISH = 3'd7;

    logic [2:0]        state;
    logic [ADDR_W-1:0] addr_q;          // start address
    logic [LEN_W-1:0]  cnt;             // words left
    logic              wr_q;
    logic              atomic_q;
    logic              rd_d;            // read strobe one cycle back
    logic [DATA_W-1:0] old_data;        // word captured by atomic read
    logic [TAG_W-1:0]  old_tag;
    logic              step;            // one batch word moves this cycle

    assign o_cmd_ready = (state == S_IDLE);
    assign o_req       = (state != S_IDLE) && (state != S_FINISH);
    assign o_wready    = (state == S_XFER) && wr_q;
    assign o_done      = (state == S_FINISH);

    // strobes, only in states reached with grant
    assign o_astb   = (state == S_ADDR);
    assign o_rd     = ((state == S_XFER) && !wr_q) || (state == S_AT_RD);
    assign o_wr     = ((state == S_XFER) && wr_q && i_wvalid) || (state == S_AT_WR);
    assign o_atomic = (state == S_AT_RD) || (state == S_AT_WR);
    assign step     = (state == S_XFER) && (o_rd || o_wr);

    always_comb begin
        o_ad  = '0;
        o_tag = '0;
        case (state)
            S_ADDR: o_ad = DATA_W'(addr_q);
            S_XFER: begin
                if (wr_q) begin
                    o_ad  = i_wdata;    // write word straight through
                    o_tag = i_wtag;
                end
            end
            S_AT_WR: begin
                o_ad  = old_data;       // RAM sets the lock bit
                o_tag = old_tag;
            end
            default: ;
        endcase
    end

    // read words come back with the RAM's one-cycle latency
    assign o_rdata  = i_bus_data;
    assign o_rtag   = i_bus_tag;
    assign o_rvalid = rd_d;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= S_IDLE;
            cnt      <= '0;
            wr_q     <= 1'b0;
            atomic_q <= 1'b0;
            rd_d     <= 1'b0;
        end else begin
            rd_d <= o_rd;
            case (state)
                S_IDLE: begin
                    if (i_cmd_valid) begin
                        cnt      <= i_cmd_len;
                        wr_q     <= i_cmd_wr;
                        atomic_q <= i_cmd_atomic;
                        state    <= S_WAIT;
                    end
                end
                S_WAIT:   if (i_gnt) state <= S_ADDR;
                S_ADDR:   state <= atomic_q ? S_AT_RD : S_XFER;
                S_XFER: begin
                    if (step) begin
                        cnt <= cnt - 1'b1;
                        if (cnt == LEN_W'(1))
                            state <= S_FINISH; // last word
                    end
                end
                S_AT_RD:  state <= S_AT_CAP;
                S_AT_CAP: state <= S_AT_WR;    // old word on the bus now
                S_AT_WR:  state <= S_FINISH;
                default:  state <= S_IDLE;     // finish, request already low
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_cmd_ready && i_cmd_valid)
            addr_q <= i_cmd_addr;
        if (state == S_AT_CAP) begin
            old_data <= i_bus_data;
            old_tag  <= i_bus_tag;
        end
    end

endmodule

/* tagmem_sys.sv */
/*
 * tagged memory with two requester peers, cpu and io, on one arbitrated bus
 * ADDR_W sets the RAM depth, 2**ADDR_W words
 * the top three word addresses are service registers
 */
`timescale 1ns/10ps

module tagmem_sys
    import tagmem_pkg::*;
#(
    parameter int ADDR_W = 20
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_cpu_cmd_valid,
    output logic              o_cpu_cmd_ready,
    input  logic [ADDR_W-1:0] i_cpu_cmd_addr,
    input  logic [LEN_W-1:0]  i_cpu_cmd_len,
    input  logic              i_cpu_cmd_wr,
    input  logic              i_cpu_cmd_atomic,
    input  logic [DATA_W-1:0] i_cpu_wdata,
    input  logic [TAG_W-1:0]  i_cpu_wtag,
    input  logic              i_cpu_wvalid,
    output logic              o_cpu_wready,
    output logic [DATA_W-1:0] o_cpu_rdata,
    output logic [TAG_W-1:0]  o_cpu_rtag,
    output logic              o_cpu_rvalid,
    output logic              o_cpu_done,
    input  logic              i_io_cmd_valid,
    output logic              o_io_cmd_ready,
    input  logic [ADDR_W-1:0] i_io_cmd_addr,
    input  logic [LEN_W-1:0]  i_io_cmd_len,
    input  logic              i_io_cmd_wr,
    input  logic              i_io_cmd_atomic,
    input  logic [DATA_W-1:0] i_io_wdata,
    input  logic [TAG_W-1:0]  i_io_wtag,
    input  logic              i_io_wvalid,
    output logic              o_io_wready,
    output logic [DATA_W-1:0] o_io_rdata,
    output logic [TAG_W-1:0]  o_io_rtag,
    output logic              o_io_rvalid,
    output logic              o_io_done
);

    logic              cpu_req, cpu_gnt, cpu_astb, cpu_rd, cpu_wr, cpu_atomic;
    logic [DATA_W-1:0] cpu_ad;
    logic [TAG_W-1:0]  cpu_tag;
    logic              io_req, io_gnt, io_astb, io_rd, io_wr, io_atomic;
    logic [DATA_W-1:0] io_ad;
    logic [TAG_W-1:0]  io_tag;
    logic              bus_astb, bus_rd, bus_wr, bus_atomic;
    logic [DATA_W-1:0] bus_ad;
    logic [TAG_W-1:0]  bus_tag;
    logic [DATA_W-1:0] ram_data;        // read data back to both peers
    logic [TAG_W-1:0]  ram_tag;

    mem_port #(.ADDR_W(ADDR_W)) cpu_port (
        .clk(clk), .i_reset(i_reset),
        .i_cmd_valid(i_cpu_cmd_valid), .o_cmd_ready(o_cpu_cmd_ready),
        .i_cmd_addr(i_cpu_cmd_addr), .i_cmd_len(i_cpu_cmd_len),
        .i_cmd_wr(i_cpu_cmd_wr), .i_cmd_atomic(i_cpu_cmd_atomic),
        .i_wdata(i_cpu_wdata), .i_wtag(i_cpu_wtag),
        .i_wvalid(i_cpu_wvalid), .o_wready(o_cpu_wready),
        .o_rdata(o_cpu_rdata), .o_rtag(o_cpu_rtag), .o_rvalid(o_cpu_rvalid),
        .o_done(o_cpu_done), .i_gnt(cpu_gnt), .o_req(cpu_req),
        .o_astb(cpu_astb), .o_rd(cpu_rd), .o_wr(cpu_wr), .o_atomic(cpu_atomic),
        .o_ad(cpu_ad), .o_tag(cpu_tag),
        .i_bus_data(ram_data), .i_bus_tag(ram_tag)
    );

    mem_port #(.ADDR_W(ADDR_W)) io_port (
        .clk(clk), .i_reset(i_reset),
        .i_cmd_valid(i_io_cmd_valid), .o_cmd_ready(o_io_cmd_ready),
        .i_cmd_addr(i_io_cmd_addr), .i_cmd_len(i_io_cmd_len),
        .i_cmd_wr(i_io_cmd_wr), .i_cmd_atomic(i_io_cmd_atomic),
        .i_wdata(i_io_wdata), .i_wtag(i_io_wtag),
        .i_wvalid(i_io_wvalid), .o_wready(o_io_wready),
        .o_rdata(o_io_rdata), .o_rtag(o_io_rtag), .o_rvalid(o_io_rvalid),
        .o_done(o_io_done), .i_gnt(io_gnt), .o_req(io_req),
        .o_astb(io_astb), .o_rd(io_rd), .o_wr(io_wr), .o_atomic(io_atomic),
        .o_ad(io_ad), .o_tag(io_tag),
        .i_bus_data(ram_data), .i_bus_tag(ram_tag)
    );

    // cpu is port 0, wins the first tie
    bus_arbiter arbiter (
        .clk(clk), .i_reset(i_reset),
        .i_req0(cpu_req), .o_gnt0(cpu_gnt),
        .i_astb0(cpu_astb), .i_rd0(cpu_rd), .i_wr0(cpu_wr), .i_atomic0(cpu_atomic),
        .i_ad0(cpu_ad), .i_tag0(cpu_tag),
        .i_req1(io_req), .o_gnt1(io_gnt),
        .i_astb1(io_astb), .i_rd1(io_rd), .i_wr1(io_wr), .i_atomic1(io_atomic),
        .i_ad1(io_ad), .i_tag1(io_tag),
        .o_astb(bus_astb), .o_rd(bus_rd), .o_wr(bus_wr), .o_atomic(bus_atomic),
        .o_ad(bus_ad), .o_tag(bus_tag)
    );

    tagmem_ram #(.ADDR_W(ADDR_W)) ram (
        .clk(clk), .i_reset(i_reset),
        .i_ad(bus_ad), .i_tag(bus_tag),
        .i_astb(bus_astb), .i_atomic(bus_atomic), .i_rd(bus_rd), .i_wr(bus_wr),
        .o_data(ram_data), .o_tag(ram_tag)
    );

endmodule

/* tb_tagmem.sv */
/*
 * testbench for tagmem_sys, built with a 10-bit word address
 * the table reads only words it wrote before, or the service registers
 * paired entries need different peers and disjoint addresses
 * tie order is predicted from the last winner, cpu takes the first tie
 */
`timescale 1ns/10ps

module tb_tagmem
    import tagmem_pkg::*;
();

    localparam int ADDR_W = 10;
    localparam int DEPTH  = 2 ** ADDR_W;
    localparam int TOP    = DEPTH - 1;
    localparam int K_RD   = 0;
    localparam int K_WR   = 1;
    localparam int K_AT   = 2;          // test-and-set
    localparam int MAX_E  = 32;

    logic              clk = 1'b0;
    logic              i_reset;
    logic [1:0]        cmd_valid, cmd_ready, cmd_wr, cmd_atomic; // bit 0 cpu, bit 1 io
    logic [1:0]        wvalid, wready, rvalid, done;
    logic [ADDR_W-1:0] cmd_addr [2];
    logic [LEN_W-1:0]  cmd_len [2];
    logic [DATA_W-1:0] wdata [2];
    logic [DATA_W-1:0] rdata [2];
    logic [TAG_W-1:0]  wtag [2];
    logic [TAG_W-1:0]  rtag [2];

    // transaction table
    int t_peer [MAX_E];
    int t_addr [MAX_E];
    int t_len [MAX_E];
    int t_kind [MAX_E];
    int t_pair [MAX_E];                 // launched together with the next entry
    int t_stall [MAX_E];                // every third write word held back
    int n_entries = 0;

    // reference model of the RAM
    logic [DATA_W-1:0]       m_data [DEPTH];
    logic [TAG_W-1:0]        m_tag [DEPTH];
    int                      m_start = 0;   // address latched by the last astb
    int                      m_last = 0;    // start of the transaction before
    int                      m_winner = 1;  // io counts as last winner out of reset
    logic [15:0]             lfsr = 16'd71;
    logic [DATA_W+TAG_W-1:0] exp_w [2][256]; // {data, tag} per read word
    logic [DATA_W+TAG_W-1:0] wr_w [2][256];
    int                      exp_n [2];

    always #5 clk = ~clk;

    tagmem_sys #(.ADDR_W(ADDR_W)) tagmem_sys_inst (
        .clk(clk), .i_reset(i_reset),
        .i_cpu_cmd_valid(cmd_valid[0]), .o_cpu_cmd_ready(cmd_ready[0]),
        .i_cpu_cmd_addr(cmd_addr[0]), .i_cpu_cmd_len(cmd_len[0]),
        .i_cpu_cmd_wr(cmd_wr[0]), .i_cpu_cmd_atomic(cmd_atomic[0]),
        .i_cpu_wdata(wdata[0]), .i_cpu_wtag(wtag[0]),
        .i_cpu_wvalid(wvalid[0]), .o_cpu_wready(wready[0]),
        .o_cpu_rdata(rdata[0]), .o_cpu_rtag(rtag[0]), .o_cpu_rvalid(rvalid[0]),
        .o_cpu_done(done[0]),
        .i_io_cmd_valid(cmd_valid[1]), .o_io_cmd_ready(cmd_ready[1]),
        .i_io_cmd_addr(cmd_addr[1]), .i_io_cmd_len(cmd_len[1]),
        .i_io_cmd_wr(cmd_wr[1]), .i_io_cmd_atomic(cmd_atomic[1]),
        .i_io_wdata(wdata[1]), .i_io_wtag(wtag[1]),
        .i_io_wvalid(wvalid[1]), .o_io_wready(wready[1]),
        .o_io_rdata(rdata[1]), .o_io_rtag(rtag[1]), .o_io_rvalid(rvalid[1]),
        .o_io_done(done[1])
    );

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // 16-bit Galois LFSR, output bit is the lsb before the step
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic bit is_svc(input int a);
        return (a == TOP - SVC_SYNDROME) || (a == TOP - SVC_LASTADDR) ||
               (a == TOP - SVC_ECCMODE);
    endfunction

    function automatic logic [DATA_W+TAG_W-1:0] model_read(input int a);
        if (a == TOP - SVC_LASTADDR)
            return {DATA_W'(m_last), TAG_W'(0)};    // tag of a service read is zero
        else if (is_svc(a))
            return '0;
        else
            return {m_data[a], m_tag[a]};
    endfunction

    task automatic add_txn(input int peer, input int addr, input int len,
                           input int kind, input int pair, input int stall);
        t_peer[n_entries]  = peer;
        t_addr[n_entries]  = addr;
        t_len[n_entries]   = len;
        t_kind[n_entries]  = kind;
        t_pair[n_entries]  = pair;
        t_stall[n_entries] = stall;
        n_entries++;
    endtask

    task automatic fill_table;
        //      peer addr                 len kind  pair stall
        add_txn(0,   'h010,               6,  K_WR, 0,   0); // batch write from cpu
        add_txn(1,   'h010,               6,  K_RD, 0,   0); // read back by io
        add_txn(0,   'h040,               7,  K_WR, 0,   1); // write with stalls
        add_txn(1,   'h040,               7,  K_RD, 0,   0);
        add_txn(0,   'h012,               1,  K_AT, 0,   0); // test-and-set, old word back
        add_txn(1,   'h012,               1,  K_RD, 0,   0); // lock bit now set
        add_txn(1,   'h012,               1,  K_AT, 0,   0); // sees the lock already taken
        add_txn(0,   TOP - SVC_SYNDROME,  1,  K_RD, 0,   0);
        add_txn(1,   TOP - SVC_ECCMODE,   1,  K_RD, 0,   0);
        add_txn(0,   TOP - SVC_LASTADDR,  1,  K_RD, 0,   0); // start of entry before
        add_txn(0,   'h080,               4,  K_WR, 1,   0); // both peers at once
        add_txn(1,   'h0c0,               4,  K_WR, 0,   0);
        add_txn(1,   'h080,               4,  K_RD, 1,   0);
        add_txn(0,   'h0c0,               4,  K_RD, 0,   0);
        add_txn(0,   TOP - SVC_LASTADDR,  1,  K_RD, 0,   0); // second one of the pair
    endtask

    // apply one entry to the model, in the order it reaches the RAM
    task automatic predict(input int e);
        int                p;
        int                a;
        int                n;
        int                j;
        int                k;
        logic [DATA_W-1:0] d;
        logic [TAG_W-1:0]  t;
        p = t_peer[e];
        a = t_addr[e];
        n = (t_kind[e] == K_AT) ? 1 : t_len[e];
        m_last   = m_start;
        m_start  = a;
        m_winner = p;
        exp_n[p] = 0;
        for (j = 0; j < n; j++) begin
            if (t_kind[e] == K_WR) begin
                for (k = 0; k < DATA_W; k++) begin
                    d[k] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                end
                for (k = 0; k < TAG_W; k++) begin
                    t[k] = lfsr[0];
                    lfsr = lfsr_next(lfsr);
                end
                wr_w[p][j] = {d, t};
                if (!is_svc(a)) begin
                    m_data[a] = d;
                    m_tag[a]  = t;
                end
                a = (a + 1) % DEPTH;
            end else begin
                exp_w[p][exp_n[p]] = model_read(a);
                exp_n[p]++;
                if (t_kind[e] == K_AT && !is_svc(a))
                    m_data[a][LOCK_BIT] = 1'b1; // old tag stays
                else if (t_kind[e] == K_RD && !is_svc(a))
                    a = (a + 1) % DEPTH;
            end
        end
    endtask

    // drive one command on its peer and follow it to o_done
    task automatic run_txn(input int e);
        int    p;
        int    n;
        int    n_rd;
        int    n_wr;
        int    held;
        bit    fin;
        bit    acc;
        string pn;
        p    = t_peer[e];
        pn   = (p == 0) ? "cpu" : "io";
        n    = (t_kind[e] == K_AT) ? 1 : t_len[e];
        n_rd = 0;
        n_wr = 0;
        held = -1;
        fin  = 1'b0;
        acc  = 1'b0;
        @(posedge clk);
        cmd_valid[p]  <= 1'b1;
        cmd_addr[p]   <= ADDR_W'(t_addr[e]);
        cmd_len[p]    <= LEN_W'(t_len[e]);
        cmd_wr[p]     <= (t_kind[e] == K_WR);
        cmd_atomic[p] <= (t_kind[e] == K_AT);
        while (!acc) begin
            @(negedge clk);
            acc = cmd_ready[p];         // taken at the coming edge
            @(posedge clk);
        end
        cmd_valid[p] <= 1'b0;
        while (!fin) begin
            if (t_kind[e] == K_WR && n_wr < n) begin
                if (t_stall[e] != 0 && n_wr % 3 == 2 && held != n_wr) begin
                    wvalid[p] <= 1'b0;          // one stall cycle
                    held = n_wr;
                end else begin
                    wvalid[p] <= 1'b1;
                    wdata[p]  <= wr_w[p][n_wr][DATA_W+TAG_W-1:TAG_W];
                    wtag[p]   <= wr_w[p][n_wr][TAG_W-1:0];
                end
            end else begin
                wvalid[p] <= 1'b0;
            end
            @(negedge clk);             // outputs settled mid-cycle
            if (rvalid[p]) begin
                if (n_rd < exp_n[p]) begin
                    check({"o_", pn, "_rdata"}, rdata[p],
                          exp_w[p][n_rd][DATA_W+TAG_W-1:TAG_W]);
                    check({"o_", pn, "_rtag"}, 64'(rtag[p]), 64'(exp_w[p][n_rd][TAG_W-1:0]));
                end
                n_rd++;
            end
            if (wready[p] && wvalid[p])
                n_wr++;
            fin = done[p];
            @(posedge clk);
        end
        wvalid[p] <= 1'b0;
        check({"o_", pn, "_rvalid count"}, 64'(n_rd), 64'(exp_n[p]));
        check({"o_", pn, "_wready words taken"}, 64'(n_wr), 64'((t_kind[e] == K_WR) ? n : 0));
    endtask

    initial begin : main
        int e;
        i_reset    = 1'b1;
        cmd_valid  = '0;
        cmd_wr     = '0;
        cmd_atomic = '0;
        wvalid     = '0;
        for (e = 0; e < 2; e++) begin
            cmd_addr[e] = '0;
            cmd_len[e]  = '0;
            wdata[e]    = '0;
            wtag[e]     = '0;
        end
        fill_table();
        repeat (8) @(posedge clk);
        i_reset <= 1'b0;
        repeat (4) begin                // quiet and ready before any command
            @(posedge clk);
            check("o_cpu_cmd_ready", 64'(cmd_ready[0]), 64'd1);
            check("o_io_cmd_ready", 64'(cmd_ready[1]), 64'd1);
            check("o_rvalid {io,cpu}", 64'(rvalid), 64'd0);
            check("o_done {io,cpu}", 64'(done), 64'd0);
            check("o_wready {io,cpu}", 64'(wready), 64'd0);
        end
        e = 0;
        while (e < n_entries) begin
            if (t_pair[e] != 0) begin
                // tie goes to the peer that did not win last
                if (t_peer[e] != m_winner) begin
                    predict(e);
                    predict(e + 1);
                end else begin
                    predict(e + 1);
                    predict(e);
                end
                fork
                    run_txn(e);
                    run_txn(e + 1);
                join
                e += 2;
            end else begin
                predict(e);
                run_txn(e);
                e++;
            end
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        int total;
        int e;
        wait (n_entries > 0);
        total = 0;
        for (e = 0; e < n_entries; e++)
            total += (t_kind[e] == K_AT) ? 1 : t_len[e];
        #((100 + 4 * total + 20 * n_entries) * 10);
        $display("timeout: the transactions did not all finish in time");
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

/* all.f */
tagmem_pkg.sv
tagmem_ram.sv
bus_arbiter.sv
mem_port.sv
tagmem_sys.sv
tb_tagmem.sv

/* Makefile */
# Verilator build and run of the tagged memory testbench

SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_tagmem: all.f $(SRCS)
	verilator --binary --timing --top-module tb_tagmem -f all.f

run: obj_dir/Vtb_tagmem
	@out="$$(./obj_dir/Vtb_tagmem 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
